//--- smpc_pkg.sv
package smpc_pkg;

	// Command codes as seen in COMREG
	typedef enum logic [7:0] {
		MSHON   = 8'h00,
		SSHON   = 8'h02,
		SSHOFF  = 8'h03,
		SNDON   = 8'h06,
		SNDOFF  = 8'h07,
		CDON    = 8'h08,
		CDOFF   = 8'h09,
		INTBACK = 8'h10,
		SETTIME = 8'h16,
		NMIREQ  = 8'h18,
		RESENAB = 8'h19,
		RESDISA = 8'h1A
	} smpc_cmd_e;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_WAIT,
		SEQ_EXEC,
		SEQ_END
	} seq_state_e;

	typedef struct packed {
		logic [15:0] year;  // BCD, four digits
		logic [3:0]  dow;
		logic [3:0]  month; // Binary 1..12
		logic [7:0]  day;
		logic [7:0]  hour;
		logic [7:0]  min;
		logic [7:0]  sec;
	} smpc_time_t;

	localparam int WAIT_CNT_W = 16;

	// Service times in CE cycles
	localparam logic [WAIT_CNT_W-1:0] WAIT_ACCEPT   = 16'd90;
	localparam logic [WAIT_CNT_W-1:0] WAIT_LINE_CMD = 16'd120;
	localparam logic [WAIT_CNT_W-1:0] WAIT_CD_CMD   = 16'd159;
	localparam logic [WAIT_CNT_W-1:0] WAIT_MISC_CMD = 16'd127;
	localparam logic [WAIT_CNT_W-1:0] WAIT_SETTIME  = 16'd279;
	localparam logic [WAIT_CNT_W-1:0] WAIT_INTBACK  = 16'd800;

	// Odd byte addresses, {A,1}
	localparam logic [6:0] ADDR_IREG0  = 7'h01;
	localparam logic [6:0] ADDR_COMREG = 7'h1F;
	localparam logic [6:0] OREG_BASE   = 7'h21;
	localparam logic [6:0] OREG_LAST   = 7'h5F;
	localparam logic [6:0] ADDR_SR     = 7'h61;
	localparam logic [6:0] ADDR_SF     = 7'h63;

	localparam int OREG_DEPTH = 32;
	localparam int OREG_AW    = 5;
	localparam logic [OREG_AW-1:0] OREG_RESULT_IDX = 5'd31;

	localparam logic [7:0] INTBACK_STATUS_KEY = 8'hF0;

	localparam smpc_time_t RTC_DEFAULT = '{
		year:  16'h2024,
		dow:   4'd0,
		month: 4'd1,
		day:   8'h01,
		hour:  8'h00,
		min:   8'h00,
		sec:   8'h00
	};

endpackage

//--- smpc_cmd_if.sv
// One-credit command hop from the host registers to the sequencer.
// The issuer owns one credit after reset and spends it with a single
// cmd_valid pulse; cmd and params hold until credit_ret comes back.
interface smpc_cmd_if;
	import smpc_pkg::*;

	logic            cmd_valid;
	smpc_cmd_e       cmd;
	logic [6:0][7:0] params;     // IREG0..IREG6
	logic            credit_ret;

	modport issuer (
		output cmd_valid,
		output cmd,
		output params,
		input  credit_ret
	);

	modport server (
		input  cmd_valid,
		input  cmd,
		input  params,
		output credit_ret
	);

endinterface

//--- smpc_oreg.sv
module smpc_oreg (
	input  logic                         CLK,
	input  logic                         we,
	input  logic [smpc_pkg::OREG_AW-1:0] wa,
	input  logic [7:0]                   wd,
	input  logic [smpc_pkg::OREG_AW-1:0] ra,
	output logic [7:0]                   q
);
	import smpc_pkg::*;

	logic [7:0] mem [OREG_DEPTH];  // Maps to distributed RAM

	always_ff @(posedge CLK) begin
		if (we)
			mem[wa] <= wd;
	end

	// Host sees a write on the following cycle
	assign q = mem[ra];

endmodule

//--- smpc_rtc.sv
module smpc_rtc #(
	parameter int TICKS_PER_SEC = 4000000
) (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 CE,
	input  logic                 time_set,
	input  smpc_pkg::smpc_time_t set_time,
	output smpc_pkg::smpc_time_t rtc_time
);
	import smpc_pkg::*;

	smpc_time_t                         now;
	logic [$clog2(TICKS_PER_SEC)-1:0]   div_cnt;
	logic                               tick;
	logic                               sec_wrap;
	logic                               min_wrap;
	logic                               hour_wrap;
	logic                               day_wrap;
	logic                               year_wrap;
	logic                               month_end;
	logic [7:0]                         year_lo;
	logic [7:0]                         year_hi;

	// Two-digit BCD increment, 99 wraps to 00
	function automatic logic [7:0] bcd_inc(input logic [7:0] v);
		if (v == 8'h99)
			return 8'h00;
		else if (v[3:0] == 4'd9)
			return {v[7:4] + 4'd1, 4'd0};
		else
			return {v[7:4], v[3:0] + 4'd1};
	endfunction

	assign tick = CE && div_cnt == ($clog2(TICKS_PER_SEC))'(TICKS_PER_SEC - 1);

	always_comb begin
		case (now.month)
			4'd2:                    month_end = now.day == 8'h28;  // No leap years
			4'd4, 4'd6, 4'd9, 4'd11: month_end = now.day == 8'h30;
			default:                 month_end = now.day == 8'h31;
		endcase
	end

	// Carries ripple within one cycle so the record never shows a half step
	assign sec_wrap  = tick && now.sec == 8'h59;
	assign min_wrap  = sec_wrap && now.min == 8'h59;
	assign hour_wrap = min_wrap && now.hour == 8'h23;
	assign day_wrap  = hour_wrap && month_end;
	assign year_wrap = day_wrap && now.month == 4'd12;

	assign year_lo = bcd_inc(now.year[7:0]);
	assign year_hi = now.year[7:0] == 8'h99 ? bcd_inc(now.year[15:8]) : now.year[15:8];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			now     <= RTC_DEFAULT;
			div_cnt <= '0;
		end else if (time_set) begin
			now     <= set_time;
			div_cnt <= '0;  // Full second after a set
		end else if (CE) begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick)
				now.sec <= sec_wrap ? 8'h00 : bcd_inc(now.sec);
			if (sec_wrap)
				now.min <= min_wrap ? 8'h00 : bcd_inc(now.min);
			if (min_wrap)
				now.hour <= hour_wrap ? 8'h00 : bcd_inc(now.hour);
			if (hour_wrap)
				now.day <= month_end ? 8'h01 : bcd_inc(now.day);
			if (day_wrap)
				now.month <= year_wrap ? 4'd1 : now.month + 4'd1;
			if (year_wrap)
				now.year <= {year_hi, year_lo};
		end
	end

	assign rtc_time = now;

	a_bcd_low_digits: assert property (@(posedge CLK) disable iff (!RST_N)
		now.sec[3:0] <= 4'd9 && now.min[3:0] <= 4'd9 && now.hour[3:0] <= 4'd9 &&
		now.day[3:0] <= 4'd9 && now.year[3:0] <= 4'd9);

endmodule

//--- smpc_host_regs.sv
module smpc_host_regs (
	input  logic                         CLK,
	input  logic                         RST_N,
	input  logic [6:1]                   A,
	input  logic [7:0]                   DI,
	input  logic                         CS_N,
	input  logic                         RW_N,
	input  logic [7:0]                   oreg_q,
	input  logic                         status_done,
	input  logic                         cmd_end,
	output logic [7:0]                   DO,
	output logic [smpc_pkg::OREG_AW-1:0] oreg_ra,
	smpc_cmd_if.issuer                   cmd
);
	import smpc_pkg::*;

	logic [6:0]      byte_addr;
	logic [6:0]      oreg_off;
	logic [6:0]      ireg_off;
	logic            rw_n_old;
	logic            cs_n_old;
	logic            wr_stb;
	logic            rd_stb;
	logic            wr_com;
	logic            credit;
	logic            credit_avail;
	logic            pend;
	logic            issue;
	logic [6:0][7:0] ireg;
	logic [7:0]      comreg;
	logic [7:0]      sr;
	logic            sf;
	logic [7:0]      do_q;
	logic            valid_q;
	smpc_cmd_e       iss_cmd;
	logic [6:0][7:0] iss_params;
	logic            in_flight;

	assign byte_addr = {A, 1'b1};
	assign oreg_off  = byte_addr - OREG_BASE;
	assign ireg_off  = byte_addr - ADDR_IREG0;
	assign oreg_ra   = oreg_off[OREG_AW:1];

	assign wr_stb = !RW_N && rw_n_old && !CS_N;  // Falling RW_N
	assign rd_stb = !CS_N && cs_n_old && RW_N;   // Falling CS_N
	assign wr_com = wr_stb && byte_addr == ADDR_COMREG;

	// A returning credit can be spent in the same cycle
	assign credit_avail = credit || cmd.credit_ret;
	assign issue        = (wr_com || pend) && credit_avail;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_old <= 1'b1;
			cs_n_old <= 1'b1;
			ireg     <= '0;
			comreg   <= '0;
			sr       <= '0;
			sf       <= 1'b0;
			do_q     <= '0;
			credit   <= 1'b1;
			pend     <= 1'b0;
			valid_q  <= 1'b0;
			iss_cmd  <= MSHON;
		end else begin
			rw_n_old <= RW_N;
			cs_n_old <= CS_N;

			valid_q <= issue;
			credit  <= credit_avail && !issue;
			pend    <= (wr_com || pend) && !issue;  // Newer COMREG overwrites
			if (issue)
				iss_cmd <= smpc_cmd_e'(wr_com ? DI : comreg);

			if (wr_stb && byte_addr <= ADDR_IREG0 + 7'd12)
				ireg[ireg_off[3:1]] <= DI;
			if (wr_com)
				comreg <= DI;

			// Stays busy while a second command is queued
			if (wr_com || (wr_stb && byte_addr == ADDR_SF && DI[0]))
				sf <= 1'b1;
			else if (cmd_end && !pend)
				sf <= 1'b0;

			if (status_done)
				sr <= 8'h4F;  // Status report ready

			if (rd_stb) begin
				if (byte_addr <= OREG_LAST)
					do_q <= oreg_q;
				else begin
					case (byte_addr)
						ADDR_SR: do_q <= sr;
						ADDR_SF: do_q <= {7'b0000000, sf};
						default: do_q <= '0;
					endcase
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (issue)
			iss_params <= ireg;
	end

	// Command sent and its credit not yet back
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			in_flight <= 1'b0;
		else if (cmd.cmd_valid)
			in_flight <= 1'b1;
		else if (cmd.credit_ret)
			in_flight <= 1'b0;
	end

	assign DO            = do_q;
	assign cmd.cmd_valid = valid_q;
	assign cmd.cmd       = iss_cmd;
	assign cmd.params    = iss_params;

	a_valid_has_credit: assert property (@(posedge CLK) disable iff (!RST_N)
		cmd.cmd_valid |-> !in_flight);

endmodule

//--- smpc_sequencer.sv
module smpc_sequencer (
	input  logic                         CLK,
	input  logic                         RST_N,
	input  logic                         CE,
	input  logic [3:0]                   AC,
	smpc_cmd_if.server                   cmd,
	input  smpc_pkg::smpc_time_t         rtc_time,
	output logic                         time_set,
	output logic                         oreg_we,
	output logic [smpc_pkg::OREG_AW-1:0] oreg_wa,
	output logic [7:0]                   oreg_wd,
	output logic                         status_done,
	output logic                         cmd_end,
	output logic                         MSHRES_N,
	output logic                         MSHNMI_N,
	output logic                         SSHRES_N,
	output logic                         SSHNMI_N,
	output logic                         SYSRES_N,
	output logic                         SNDRES_N,
	output logic                         CDRES_N,
	output logic                         MIRQ_N
);
	import smpc_pkg::*;

	seq_state_e              state;
	logic [WAIT_CNT_W-1:0]   timer;
	logic                    svc_phase;
	logic [OREG_AW-1:0]      oreg_cnt;
	logic                    resd;
	logic                    ste;
	logic                    credit_q;
	logic                    report_en;
	logic [7:0]              rpt_byte;

	function automatic logic [WAIT_CNT_W-1:0] svc_time(input smpc_cmd_e c);
		case (c)
			MSHON, SSHON, SSHOFF, SNDON, SNDOFF: return WAIT_LINE_CMD;
			CDON, CDOFF:                         return WAIT_CD_CMD;
			NMIREQ, RESENAB, RESDISA:            return WAIT_MISC_CMD;
			SETTIME:                             return WAIT_SETTIME;
			INTBACK:                             return WAIT_INTBACK;
			default:                             return WAIT_CNT_W'(1);
		endcase
	endfunction

	assign SYSRES_N = 1'b1;  // No system reset command left
	assign cmd.credit_ret = credit_q;
	assign report_en = cmd.cmd == INTBACK && cmd.params[2] == INTBACK_STATUS_KEY &&
		cmd.params[0][0];

	always_comb begin
		case (oreg_cnt)
			5'd0:            rpt_byte = {ste, resd, 6'b000000};
			5'd1:            rpt_byte = rtc_time.year[15:8];
			5'd2:            rpt_byte = rtc_time.year[7:0];
			5'd3:            rpt_byte = {rtc_time.dow, rtc_time.month};
			5'd4:            rpt_byte = rtc_time.day;
			5'd5:            rpt_byte = rtc_time.hour;
			5'd6:            rpt_byte = rtc_time.min;
			5'd7:            rpt_byte = rtc_time.sec;
			5'd9:            rpt_byte = {4'b0000, AC};
			5'd10:           rpt_byte = {4'b0011, ~MSHNMI_N, 1'b1, ~SYSRES_N, ~SNDRES_N};
			5'd11:           rpt_byte = {1'b0, ~CDRES_N, 6'b000000};
			OREG_RESULT_IDX: rpt_byte = cmd.cmd;
			default:         rpt_byte = 8'h00;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state       <= SEQ_IDLE;
			timer       <= '0;
			svc_phase   <= 1'b0;
			oreg_cnt    <= '0;
			resd        <= 1'b1;
			ste         <= 1'b0;
			MSHRES_N    <= 1'b1;
			MSHNMI_N    <= 1'b1;
			SSHRES_N    <= 1'b0;
			SSHNMI_N    <= 1'b1;
			SNDRES_N    <= 1'b0;
			CDRES_N     <= 1'b1;
			MIRQ_N      <= 1'b1;
			time_set    <= 1'b0;
			oreg_we     <= 1'b0;
			oreg_wa     <= '0;
			oreg_wd     <= '0;
			status_done <= 1'b0;
			cmd_end     <= 1'b0;
			credit_q    <= 1'b0;
		end else begin
			time_set    <= 1'b0;
			oreg_we     <= 1'b0;
			status_done <= 1'b0;
			cmd_end     <= 1'b0;
			credit_q    <= 1'b0;

			if (state == SEQ_IDLE) begin
				// Accepted regardless of CE, the pulse is one clock wide
				if (cmd.cmd_valid) begin
					timer     <= WAIT_ACCEPT - 1'b1;
					svc_phase <= 1'b0;
					oreg_cnt  <= '0;
					MIRQ_N    <= 1'b1;
					state     <= SEQ_WAIT;
				end
			end else if (CE) begin
				case (state)
					SEQ_WAIT: begin
						if (timer != '0)
							timer <= timer - 1'b1;
						else if (!svc_phase) begin
							svc_phase <= 1'b1;
							timer     <= svc_time(cmd.cmd) - 1'b1;
						end else
							state <= SEQ_EXEC;
					end
					SEQ_EXEC: begin
						oreg_we <= 1'b1;
						if (report_en) begin
							oreg_wa  <= oreg_cnt;
							oreg_wd  <= rpt_byte;
							oreg_cnt <= oreg_cnt + 1'b1;
							if (oreg_cnt == OREG_RESULT_IDX) begin
								status_done <= 1'b1;
								MIRQ_N      <= 1'b0;
								state       <= SEQ_END;
							end
						end else begin
							oreg_wa <= OREG_RESULT_IDX;
							oreg_wd <= cmd.cmd;
							case (cmd.cmd)
								MSHON: begin
									MSHRES_N <= 1'b1;
									MSHNMI_N <= 1'b1;
								end
								SSHON: begin
									SSHRES_N <= 1'b1;
									SSHNMI_N <= 1'b1;
								end
								SSHOFF: begin
									SSHRES_N <= 1'b0;
									SSHNMI_N <= 1'b1;
								end
								SNDON:   SNDRES_N <= 1'b1;
								SNDOFF:  SNDRES_N <= 1'b0;
								CDON:    CDRES_N  <= 1'b1;
								CDOFF:   CDRES_N  <= 1'b0;
								NMIREQ:  MSHNMI_N <= 1'b0;  // Released in END
								RESENAB: resd     <= 1'b0;
								RESDISA: resd     <= 1'b1;
								SETTIME: begin
									ste      <= 1'b1;
									time_set <= 1'b1;
								end
								default: ;
							endcase
							state <= SEQ_END;
						end
					end
					SEQ_END: begin
						if (cmd.cmd == NMIREQ)
							MSHNMI_N <= 1'b1;
						cmd_end  <= 1'b1;
						credit_q <= 1'b1;
						state    <= SEQ_IDLE;
					end
					default: state <= SEQ_IDLE;
				endcase
			end
		end
	end

	// New command only once the credit from SEQ_END is back
	a_cmd_when_idle: assert property (@(posedge CLK) disable iff (!RST_N)
		cmd.cmd_valid |-> state == SEQ_IDLE);

	a_params_held: assert property (@(posedge CLK) disable iff (!RST_N)
		state != SEQ_IDLE |-> $stable(cmd.params) && $stable(cmd.cmd));

endmodule

//--- smpc_top.sv
module smpc_top #(
	parameter int TICKS_PER_SEC = 4000000
) (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       CE,
	input  logic [3:0] AC,
	input  logic [6:1] A,
	input  logic [7:0] DI,
	output logic [7:0] DO,
	input  logic       CS_N,
	input  logic       RW_N,
	output logic       MSHRES_N,
	output logic       MSHNMI_N,
	output logic       SSHRES_N,
	output logic       SSHNMI_N,
	output logic       SYSRES_N,
	output logic       SNDRES_N,
	output logic       CDRES_N,
	output logic       MIRQ_N
);
	import smpc_pkg::*;

	smpc_cmd_if cmd_bus ();

	logic [7:0]         oreg_q;
	logic [OREG_AW-1:0] oreg_ra;
	logic               oreg_we;
	logic [OREG_AW-1:0] oreg_wa;
	logic [7:0]         oreg_wd;
	logic               time_set;
	smpc_time_t         set_time;
	smpc_time_t         rtc_time;
	logic               status_done;
	logic               cmd_end;

	// IREG0..6 hold year hi/lo, dow+month, day, hour, min, sec
	assign set_time = {cmd_bus.params[0], cmd_bus.params[1], cmd_bus.params[2],
		cmd_bus.params[3], cmd_bus.params[4], cmd_bus.params[5], cmd_bus.params[6]};

	smpc_host_regs u_host_regs (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.A           (A),
		.DI          (DI),
		.CS_N        (CS_N),
		.RW_N        (RW_N),
		.oreg_q      (oreg_q),
		.status_done (status_done),
		.cmd_end     (cmd_end),
		.DO          (DO),
		.oreg_ra     (oreg_ra),
		.cmd         (cmd_bus)
	);

	smpc_sequencer u_sequencer (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.CE          (CE),
		.AC          (AC),
		.cmd         (cmd_bus),
		.rtc_time    (rtc_time),
		.time_set    (time_set),
		.oreg_we     (oreg_we),
		.oreg_wa     (oreg_wa),
		.oreg_wd     (oreg_wd),
		.status_done (status_done),
		.cmd_end     (cmd_end),
		.MSHRES_N    (MSHRES_N),
		.MSHNMI_N    (MSHNMI_N),
		.SSHRES_N    (SSHRES_N),
		.SSHNMI_N    (SSHNMI_N),
		.SYSRES_N    (SYSRES_N),
		.SNDRES_N    (SNDRES_N),
		.CDRES_N     (CDRES_N),
		.MIRQ_N      (MIRQ_N)
	);

	smpc_rtc #(
		.TICKS_PER_SEC (TICKS_PER_SEC)
	) u_rtc (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.CE       (CE),
		.time_set (time_set),
		.set_time (set_time),
		.rtc_time (rtc_time)
	);

	smpc_oreg u_oreg (
		.CLK (CLK),
		.we  (oreg_we),
		.wa  (oreg_wa),
		.wd  (oreg_wd),
		.ra  (oreg_ra),
		.q   (oreg_q)
	);

endmodule

//--- tb_smpc.sv
module tb_smpc;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ROWS = 9;
	localparam int SF_POLL_LIMIT = 1000;
	localparam int ROLL_TRIES = 12;
	localparam logic [5:0] A_COMREG = 6'h0F;
	localparam logic [5:0] A_OREG0 = 6'h10;
	localparam logic [5:0] A_SR = 6'h30;
	localparam logic [5:0] A_SF = 6'h31;
	localparam logic [6:0] RESET_LINES = 7'b1101101;
	localparam logic [3:0] AC_VALUE = 4'hA;

	typedef struct packed {
		logic [7:0]  cmd;
		logic [55:0] params;  // IREG0 in the top byte
		logic [6:0]  lines;   // MSHRES, MSHNMI, SSHRES, SSHNMI, SYSRES, SNDRES, CDRES
	} cmd_row_t;

	logic CLK;
	logic RST_N;
	logic ce;
	logic [3:0] ac;
	logic [6:1] a;
	logic [7:0] di;
	logic [7:0] dout;
	logic cs_n;
	logic rw_n;
	logic mshres_n, mshnmi_n, sshres_n, sshnmi_n, sysres_n, sndres_n, cdres_n, mirq_n;
	logic [6:0] lines;

	cmd_row_t cmd_rows [ROWS];
	logic [7:0] report [32];
	logic [7:0] rd;
	logic [6:0] exp_lines;
	logic exp_ste;
	logic exp_resd;
	int errors;
	int checks;
	int tries;

	assign lines = {mshres_n, mshnmi_n, sshres_n, sshnmi_n, sysres_n, sndres_n, cdres_n};

	smpc_top #(
		.TICKS_PER_SEC (5000)
	) UUT (
		.CLK (CLK), .RST_N (RST_N), .CE (ce), .AC (ac), .A (a), .DI (di), .DO (dout),
		.CS_N (cs_n), .RW_N (rw_n), .MSHRES_N (mshres_n), .MSHNMI_N (mshnmi_n),
		.SSHRES_N (sshres_n), .SSHNMI_N (sshnmi_n), .SYSRES_N (sysres_n),
		.SNDRES_N (sndres_n), .CDRES_N (cdres_n), .MIRQ_N (mirq_n)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	// RW_N falls one cycle after CS_N
	task automatic write_reg(input logic [5:0] addr, input logic [7:0] data);
		@(posedge CLK);
		a <= addr;
		di <= data;
		cs_n <= 1'b0;
		rw_n <= 1'b1;
		@(posedge CLK);
		rw_n <= 1'b0;
		@(posedge CLK);
		cs_n <= 1'b1;
		rw_n <= 1'b1;
	endtask

	task automatic read_reg(input logic [5:0] addr, output logic [7:0] data);
		@(posedge CLK);
		a <= addr;
		cs_n <= 1'b0;
		rw_n <= 1'b1;
		@(posedge CLK);  // DO latched here
		@(negedge CLK);
		data = dout;
		@(posedge CLK);
		cs_n <= 1'b1;
	endtask

	task automatic wait_cmd_done();
		logic [7:0] sf;
		int polls;
		polls = 0;
		sf = 8'h01;
		while (sf[0] && polls < SF_POLL_LIMIT) begin
			read_reg(A_SF, sf);
			polls++;
		end
		if (sf[0]) begin
			errors++;
			$display("Timeout at %0t ns: SF still set after %0d polls", $time, polls);
		end
	endtask

	task automatic write_params(input logic [55:0] p);
		for (int k = 0; k < 7; k++)
			write_reg(6'(k), p[55 - 8 * k -: 8]);
	endtask

	task automatic send_cmd(input logic [7:0] code);
		write_reg(A_COMREG, code);
		wait_cmd_done();
	endtask

	task automatic run_intback();
		write_reg(6'h00, 8'h01);  // Status report on
		write_reg(6'h02, 8'hF0);
		send_cmd(8'h10);
		for (int i = 0; i < 32; i++)
			read_reg(A_OREG0 + 6'(i), report[i]);
	endtask

	function automatic logic [7:0] report_byte10(input logic [6:0] l);
		return {4'b0011, ~l[5], 1'b1, ~l[2], ~l[1]};
	endfunction

	function automatic logic [7:0] report_byte11(input logic [6:0] l);
		return {1'b0, ~l[0], 6'b000000};
	endfunction

	initial begin
		RST_N = 1'b0;
		ce = 1'b1;
		ac = AC_VALUE;
		a = '0;
		di = '0;
		cs_n = 1'b1;
		rw_n = 1'b1;
		errors = 0;
		checks = 0;
		exp_ste = 1'b0;
		exp_resd = 1'b1;
		cmd_rows[0] = '{8'h00, 56'h0, 7'b1101101};
		cmd_rows[1] = '{8'h02, 56'h0, 7'b1111101};
		cmd_rows[2] = '{8'h06, 56'h0, 7'b1111111};
		cmd_rows[3] = '{8'h09, 56'h0, 7'b1111110};
		cmd_rows[4] = '{8'h03, 56'h0, 7'b1101110};
		cmd_rows[5] = '{8'h07, 56'h0, 7'b1101100};
		cmd_rows[6] = '{8'h08, 56'h0, 7'b1101101};
		cmd_rows[7] = '{8'h05, 56'h0, 7'b1101101};  // Not a valid opcode
		cmd_rows[8] = '{8'h16, 56'h20313715123456, 7'b1101101};

		repeat (3) @(posedge CLK);
		RST_N <= 1'b1;
		@(negedge CLK);
		compare("lines", {1'b0, lines}, {1'b0, RESET_LINES});
		compare("MIRQ_N", {7'b0, mirq_n}, 8'h01);
		read_reg(A_SF, rd);
		compare("SF", rd, 8'h00);
		read_reg(A_SR, rd);
		compare("SR", rd, 8'h00);

		for (int i = 0; i < ROWS; i++) begin
			write_params(cmd_rows[i].params);
			send_cmd(cmd_rows[i].cmd);
			if (cmd_rows[i].cmd == 8'h16)
				exp_ste = 1'b1;
			exp_lines = cmd_rows[i].lines;
			@(negedge CLK);
			compare($sformatf("lines row %0d", i), {1'b0, lines}, {1'b0, exp_lines});
			read_reg(A_OREG0 + 6'd31, rd);
			compare($sformatf("OREG31 row %0d", i), rd, cmd_rows[i].cmd);
		end

		// Report right after SETTIME, well inside one second
		run_intback();
		for (int k = 1; k < 8; k++)
			compare($sformatf("OREG%0d", k), report[k], cmd_rows[ROWS-1].params[63 - 8 * k -: 8]);
		compare("OREG0", report[0], {exp_ste, exp_resd, 6'b000000});
		compare("OREG8", report[8], 8'h00);
		compare("OREG9", report[9], {4'b0000, AC_VALUE});
		compare("OREG10", report[10], report_byte10(exp_lines));
		compare("OREG11", report[11], report_byte11(exp_lines));
		compare("OREG31", report[31], 8'h10);
		read_reg(A_SR, rd);
		compare("SR", rd, 8'h4F);
		@(negedge CLK);
		compare("MIRQ_N", {7'b0, mirq_n}, 8'h00);

		send_cmd(8'h19);
		exp_resd = 1'b0;
		run_intback();
		compare("OREG0 after RESENAB", report[0], {exp_ste, exp_resd, 6'b000000});
		send_cmd(8'h1A);
		exp_resd = 1'b1;
		run_intback();
		compare("OREG0 after RESDISA", report[0], {exp_ste, exp_resd, 6'b000000});

		// 1999-12-31 23:59:59, day-of-week 5
		write_params(56'h19995C31235959);
		send_cmd(8'h16);
		tries = 0;
		report[7] = 8'h59;
		while (report[7] == 8'h59 && tries < ROLL_TRIES) begin
			run_intback();
			tries++;
		end
		if (report[7] == 8'h59) begin
			errors++;
			$display("Timeout at %0t ns: clock second never left 59", $time);
		end
		compare("year hi", report[1], 8'h20);
		compare("year lo", report[2], 8'h00);
		compare("dow/month", report[3], 8'h51);
		compare("day", report[4], 8'h01);
		compare("hour", report[5], 8'h00);
		compare("minute", report[6], 8'h00);
		compare("second", report[7], 8'h00);

		// Second command waits for the credit
		write_reg(A_COMREG, 8'h06);
		write_reg(A_COMREG, 8'h09);
		wait_cmd_done();
		exp_lines[1] = 1'b1;
		exp_lines[0] = 1'b0;
		@(negedge CLK);
		compare("lines back-pressure", {1'b0, lines}, {1'b0, exp_lines});
		compare("MIRQ_N", {7'b0, mirq_n}, 8'h01);
		read_reg(A_OREG0 + 6'd31, rd);
		compare("OREG31", rd, 8'h09);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- files.f
smpc_pkg.sv
smpc_cmd_if.sv
smpc_oreg.sv
smpc_rtc.sv
smpc_host_regs.sv
smpc_sequencer.sv
smpc_top.sv
tb_smpc.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_smpc -o sim_smpc
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/sim_smpc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
	exit 0
fi
echo "Simulation reported failures"
exit 1
